/* bench/dsi3_chip_filter_chk.sv */
// Assertion checker for the DSI3 chip filter
// Watches the Wishbone handshake and the filtered chip inside the top level

`timescale 1ns/1ns
`default_nettype none

module dsi3_chip_filter_chk (
  input wire       clk_rst,
  input wire       i_arst_n,
  input wire       i_wb_cyc,
  input wire       i_wb_stb,
  input wire       i_wb_ack,
  input wire [1:0] i_filtered_chip,
  input wire       i_chg_pulse
);

  // ~~~~~~~~~~~~~~~~~~~~ Bus handshake
  ack_one_cycle: assert property (@(posedge clk_rst) disable iff (!i_arst_n)
    i_wb_ack |=> !i_wb_ack) else $error("Wishbone ack held for more than one cycle");

  ack_needs_req: assert property (@(posedge clk_rst) disable iff (!i_arst_n)
    i_wb_ack |-> $past(i_wb_cyc && i_wb_stb)) else $error("Wishbone ack without a request");

  // ~~~~~~~~~~~~~~~~~~~~ Filter output
  chip_valid: assert property (@(posedge clk_rst) disable iff (!i_arst_n)
    i_filtered_chip != 2'd3) else $error("Filtered chip holds the invalid code 3");

  pulse_on_change: assert property (@(posedge clk_rst) disable iff (!i_arst_n)
    i_chg_pulse |-> (i_filtered_chip != $past(i_filtered_chip)))
    else $error("Change pulse without a change of the filtered chip");

endmodule : dsi3_chip_filter_chk

bind dsi3_chip_filter_top dsi3_chip_filter_chk u_chk (
  .clk_rst         (clk_rst),
  .i_arst_n        (i_arst_n),
  .i_wb_cyc        (i_wb_cyc),
  .i_wb_stb        (i_wb_stb),
  .i_wb_ack        (o_wb_ack),
  .i_filtered_chip (filtered_chip),
  .i_chg_pulse     (chg_pulse)
);

`default_nettype wire

/* bench/filter_cases.txt */
// Columns in hex: short flag, input chip, hold in clock cycles, expected filtered chip
// The expected chip is sampled after the last cycle of the hold
0 0 08 0
0 1 0F 0   // One cycle short of the long limit
0 1 01 1
0 1 10 1
1 2 0A 1   // One cycle short of the short limit
1 2 01 2
1 2 10 2
1 0 0B 1   // Direct jump C2 to C0 passes through C1
1 0 02 0
1 0 10 0
0 2 10 1   // Direct jump C0 to C2 in long mode
0 2 02 2
0 2 10 2
0 1 10 1
0 0 0F 1
0 0 01 0
0 0 14 0

/* bench/tb_dsi3_chip_filter.sv */
// Testbench for the DSI3 chip filter
// Replays the case table on the raw chip input and checks the filtered chip
// after each hold, adds random short glitches and checks the register slave

`timescale 1ns/1ns
`default_nettype none

module tb_dsi3_chip_filter;

  import dsi3_pkg::*;

  localparam int N_CASES  = 17;                  // Lines in the case table
  localparam int N_GLITCH = 12;                  // Random glitch bursts after the table

  logic             clk_rst;
  logic             arst_n;
  dsi3_chip         chip;                        // Raw chip into the DUT
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [WB_AW-1:0] wb_adr;
  logic [31:0]      wb_dat_w;
  logic [31:0]      wb_dat_r;
  logic             wb_ack;
  dsi3_chip         filtered_chip;

  logic [7:0]  case_mem [0:4*N_CASES-1];         // Short flag, chip, hold, expected per case
  logic [31:0] rng_state = 32'h77b5_c75c;
  logic [31:0] rd_word;                          // Last word read over the bus
  logic        cur_short;                        // Filter mode currently in the DUT
  logic        driven;                           // Chip of the next case already applied
  logic [1:0]  last_exp;                         // Filtered chip at the end of the table
  int unsigned n_changes;                        // Output changes implied by the table
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 32'hFFFF_FFFF;      // Lowered once the table is known

  dsi3_chip_filter_top UUT (
    .clk_rst         (clk_rst),
    .i_arst_n        (arst_n),
    .i_chip          (chip),
    .i_wb_cyc        (wb_cyc),
    .i_wb_stb        (wb_stb),
    .i_wb_we         (wb_we),
    .i_wb_adr        (wb_adr),
    .i_wb_dat        (wb_dat_w),
    .o_filtered_chip (filtered_chip),
    .o_wb_dat        (wb_dat_r),
    .o_wb_ack        (wb_ack)
  );

  initial begin
    clk_rst = 1'b0;
    forever #10 clk_rst = ~clk_rst;              // 20 ns period
  end

  always @(posedge clk_rst) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~ Helpers
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s expected 0x%0h got 0x%0h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "Value mismatch");
    end
  endtask

  // One Wishbone classic transfer, returns on the edge that drops stb
  task automatic bus_transfer(input logic we, input logic [WB_AW-1:0] adr,
                              input logic [31:0] dat, output logic [31:0] rd);
    @(posedge clk_rst);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    @(negedge clk_rst);
    while (!wb_ack) begin
      @(negedge clk_rst);
    end
    rd = wb_dat_r;                               // Read data is valid while ack is high
    @(posedge clk_rst);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  // Each glitch is followed by the filtered value for as many cycles, so every count decays
  task automatic run_glitches(input logic [1:0] base);
    int unsigned limit;
    int unsigned glen;
    int          gval;
    int          g;
    limit = cur_short ? FILT_MAX_SHORT : FILT_MAX_LONG;
    for (g = 0; g < N_GLITCH; g++) begin
      rng_state = lcg_step(rng_state);
      glen = 1 + (rng_state[23:8] % (limit - 1)); // Always below the limit
      gval = (base + 1 + rng_state[28]) % 3;     // One of the two other chip values
      @(posedge clk_rst);
      chip <= dsi3_chip'(gval);
      repeat (glen) @(posedge clk_rst);
      chip <= dsi3_chip'(base);
      repeat (glen) @(posedge clk_rst);
      @(negedge clk_rst);
      check_value($sformatf("o_filtered_chip (glitch %0d)", g), base, filtered_chip);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~ Test sequence
  initial begin
    int unsigned hold_sum;
    int          i;
    logic [1:0]  prev;
    arst_n    = 1'b0;
    chip      = C0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    cur_short = 1'b0;
    driven    = 1'b0;
    $readmemh("bench/filter_cases.txt", case_mem);
    hold_sum  = 0;
    n_changes = 0;
    prev      = C0;                              // Filtered chip after reset
    for (i = 0; i < N_CASES; i++) begin
      if ($isunknown({case_mem[4*i], case_mem[4*i+1], case_mem[4*i+2], case_mem[4*i+3]})) begin
        $display("The case table bench/filter_cases.txt is missing or has fewer lines");
        $display("=== FAIL ===");
        $fatal(1, "Unusable case table");
      end
      hold_sum += case_mem[4*i+2];
      if (case_mem[4*i+3][1:0] != prev) begin
        n_changes++;                             // Each new expected value is one transition
      end
      prev = case_mem[4*i+3][1:0];
    end
    last_exp    = prev;
    cycle_limit = hold_sum + N_GLITCH * (2 * FILT_MAX_LONG + 2) + 200;

    repeat (2) @(posedge clk_rst);
    arst_n <= 1'b1;

    // Register state straight after reset
    bus_transfer(1'b0, ADDR_STAT, 32'd0, rd_word);
    check_value("o_wb_dat (status after reset)", 32'd0, rd_word);
    bus_transfer(1'b0, ADDR_CTRL, 32'd0, rd_word);
    check_value("o_wb_dat (control after reset)", 32'd0, rd_word);
    bus_transfer(1'b1, ADDR_CTRL, 32'd1, rd_word);
    bus_transfer(1'b0, ADDR_CTRL, 32'd0, rd_word);
    check_value("o_wb_dat (control readback)", 32'd1, rd_word);
    bus_transfer(1'b1, ADDR_CTRL, 32'd0, rd_word);

    for (i = 0; i < N_CASES; i++) begin
      if (!driven) begin
        if (case_mem[4*i][0] != cur_short) begin
          cur_short = case_mem[4*i][0];          // Mode switch while the filter is settled
          bus_transfer(1'b1, ADDR_CTRL, {31'd0, cur_short}, rd_word);
        end else begin
          @(posedge clk_rst);
        end
        chip <= dsi3_chip'(case_mem[4*i+1][1:0]);
      end
      repeat (case_mem[4*i+2]) @(posedge clk_rst);
      driven = (i + 1 < N_CASES) && (case_mem[4*i+4][0] == cur_short);
      if (driven) begin
        chip <= dsi3_chip'(case_mem[4*i+5][1:0]); // Next case starts on this edge
      end
      @(negedge clk_rst);
      check_value($sformatf("o_filtered_chip (case %0d)", i), case_mem[4*i+3], filtered_chip);
    end

    run_glitches(last_exp);

    bus_transfer(1'b0, ADDR_STAT, 32'd0, rd_word);
    check_value("o_wb_dat[1:0] (filtered chip)", last_exp, rd_word[1:0]);
    check_value("o_wb_dat[31:16] (transition count)", n_changes, rd_word[31:16]);
    bus_transfer(1'b1, ADDR_CTRL, {30'd0, 1'b1, cur_short}, rd_word);
    bus_transfer(1'b0, ADDR_STAT, 32'd0, rd_word);
    check_value("o_wb_dat[31:16] (count after clear)", 32'd0, rd_word[31:16]);
    bus_transfer(1'b0, ADDR_CTRL, 32'd0, rd_word);
    check_value("o_wb_dat (control after clear)", {31'd0, cur_short}, rd_word);

    $display("=== PASS ===");
    $finish;
  end

endmodule : tb_dsi3_chip_filter

`default_nettype wire

/* flist.f */
hdl/dsi3_pkg.sv
hdl/dsi3_chip_filter_counter.sv
hdl/dsi3_chip_filter_decision.sv
hdl/dsi3_filter_regs.sv
hdl/dsi3_chip_filter_top.sv
bench/dsi3_chip_filter_chk.sv
bench/tb_dsi3_chip_filter.sv

/* hdl/dsi3_chip_filter_counter.sv */
// DSI3 chip filter counter
// Measures how long one chip value has been present while it is not the
// filtered chip; counts up on a match and down otherwise, saturating at both ends.
// The instance for C1 also counts on a direct jump between the outer levels.

`timescale 1ns/1ns
`default_nettype none

module dsi3_chip_filter_counter #(
  parameter dsi3_pkg::dsi3_chip COUNT_VALUE = dsi3_pkg::C0      // Chip value this counter watches
) (
  input  wire                            clk_rst,
  input  wire                            i_arst_n,
  input  wire dsi3_pkg::dsi3_chip        i_input_value,         // Raw chip from the comparator
  input  wire dsi3_pkg::dsi3_chip        i_filtered_value,      // Current filter output
  input  wire                            i_shorter_filter_time, // Selects the short limit
  output dsi3_pkg::dsi3_filter_counter_t o_cnt
);

  import dsi3_pkg::*;

  dsi3_filter_counter_t max_value;               // Active saturation limit
  dsi3_filter_counter_t cnt_nxt;                 // Next count value
  logic                 count_up;                // Input supports this value
  logic                 restart;                 // Count goes back to zero

  assign max_value = i_shorter_filter_time ? FILT_MAX_SHORT : FILT_MAX_LONG;

  // ~~~~~~~~~~~~~~~~~~~~ Count conditions
  generate
    if (COUNT_VALUE == C1) begin : g_mid_level
      dsi3_chip prev_filtered;                   // Filter output of the last cycle
      logic     outer_jump;                      // Input jumps across the middle level

      // A C0/C2 swap must pass through C1, so it also counts for C1
      assign outer_jump = ((i_input_value == C0) && (i_filtered_value == C2)) ||
                          ((i_input_value == C2) && (i_filtered_value == C0));

      assign count_up = (i_input_value == COUNT_VALUE) || outer_jump;

      // Any change of the filter output starts the middle count afresh
      assign restart = (i_filtered_value == COUNT_VALUE) ||
                       (i_filtered_value != prev_filtered);

      always_ff @(posedge clk_rst or negedge i_arst_n) begin
        if (!i_arst_n) begin
          prev_filtered <= C0;                   // Filter output comes out of reset as C0
        end else begin
          prev_filtered <= i_filtered_value;
        end
      end
    end else begin : g_outer_level
      assign count_up = (i_input_value == COUNT_VALUE);     // Only an exact match counts up
      assign restart  = (i_filtered_value == COUNT_VALUE);  // Idle while this value is output
    end
  endgenerate

  // ~~~~~~~~~~~~~~~~~~~~ Next count
  always_comb begin
    cnt_nxt = o_cnt;                             // Hold at either saturation point
    if (restart) begin
      cnt_nxt = '0;
    end else if (count_up) begin
      if (o_cnt < max_value) begin
        cnt_nxt = o_cnt + 4'd1;                  // Value persists, count towards the limit
      end
    end else if (o_cnt != '0) begin
      cnt_nxt = o_cnt - 4'd1;                    // Value absent, let the count decay
    end
  end

  always_ff @(posedge clk_rst or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_cnt <= '0;
    end else begin
      o_cnt <= cnt_nxt;                          // Count reflects the input one cycle later
    end
  end

endmodule : dsi3_chip_filter_counter

`default_nettype wire

/* hdl/dsi3_chip_filter_decision.sv */
// DSI3 chip filter decision
// Compares the three persistence counts with the active limit, picks the new
// filtered chip by priority C1, C0, C2 and flags each change for one cycle

`timescale 1ns/1ns
`default_nettype none

module dsi3_chip_filter_decision (
  input  wire                                 clk_rst,
  input  wire                                 i_arst_n,
  input  wire dsi3_pkg::dsi3_filter_counter_t i_cnt_c0,              // Persistence of C0
  input  wire dsi3_pkg::dsi3_filter_counter_t i_cnt_c1,              // Persistence of C1
  input  wire dsi3_pkg::dsi3_filter_counter_t i_cnt_c2,              // Persistence of C2
  input  wire                                 i_shorter_filter_time, // Selects the short limit
  output dsi3_pkg::dsi3_chip                  o_filtered_chip,
  output logic                                o_chip_changed
);

  import dsi3_pkg::*;

  dsi3_filter_counter_t limit;                   // Active switching threshold
  logic                 hit_c0;                  // C0 count has reached the limit
  logic                 hit_c1;                  // C1 count has reached the limit
  logic                 hit_c2;                  // C2 count has reached the limit
  dsi3_chip             chip_nxt;                // Filtered chip for the next cycle

  assign limit = i_shorter_filter_time ? FILT_MAX_SHORT : FILT_MAX_LONG;

  // A count may sit above a freshly lowered limit, so compare with >=
  assign hit_c0 = (i_cnt_c0 >= limit);
  assign hit_c1 = (i_cnt_c1 >= limit);
  assign hit_c2 = (i_cnt_c2 >= limit);

  // ~~~~~~~~~~~~~~~~~~~~ Priority select
  always_comb begin
    chip_nxt = o_filtered_chip;                  // No count at the limit keeps the output
    if (hit_c1) begin
      chip_nxt = C1;                             // Middle level wins every tie
    end else if (hit_c0) begin
      chip_nxt = C0;
    end else if (hit_c2) begin
      chip_nxt = C2;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~ Output registers
  always_ff @(posedge clk_rst or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_filtered_chip <= C0;
      o_chip_changed  <= 1'b0;
    end else begin
      o_filtered_chip <= chip_nxt;                       // Switch one cycle after the hit
      o_chip_changed  <= (chip_nxt != o_filtered_chip);  // High in the first cycle of a new chip
    end
  end

endmodule : dsi3_chip_filter_decision

`default_nettype wire

/* hdl/dsi3_chip_filter_top.sv */
// DSI3 chip filter top level
// Three persistence counters run side by side on the raw chip, the decision
// block forms the filtered chip, and a Wishbone slave holds control and status

`timescale 1ns/1ns
`default_nettype none

module dsi3_chip_filter_top (
  input  wire                       clk_rst,
  input  wire                       i_arst_n,
  input  wire dsi3_pkg::dsi3_chip   i_chip,          // Raw chip, one sample per cycle
  input  wire                       i_wb_cyc,
  input  wire                       i_wb_stb,
  input  wire                       i_wb_we,
  input  wire [dsi3_pkg::WB_AW-1:0] i_wb_adr,
  input  wire [31:0]                i_wb_dat,
  output dsi3_pkg::dsi3_chip        o_filtered_chip,
  output logic [31:0]               o_wb_dat,
  output logic                      o_wb_ack
);

  import dsi3_pkg::*;

  dsi3_filter_counter_t cnt_c0;                  // Persistence counts
  dsi3_filter_counter_t cnt_c1;
  dsi3_filter_counter_t cnt_c2;
  dsi3_chip             filtered_chip;           // Fed back to every counter
  logic                 chg_pulse;               // Filter output changed
  logic                 short_sel;               // Short filter time from software

  assign o_filtered_chip = filtered_chip;

  // ~~~~~~~~~~~~~~~~~~~~ Counters
  dsi3_chip_filter_counter #(.COUNT_VALUE(C0)) u_cnt_c0 (
    .clk_rst               (clk_rst),
    .i_arst_n              (i_arst_n),
    .i_input_value         (i_chip),
    .i_filtered_value      (filtered_chip),
    .i_shorter_filter_time (short_sel),
    .o_cnt                 (cnt_c0)
  );

  dsi3_chip_filter_counter #(.COUNT_VALUE(C1)) u_cnt_c1 (
    .clk_rst               (clk_rst),
    .i_arst_n              (i_arst_n),
    .i_input_value         (i_chip),
    .i_filtered_value      (filtered_chip),
    .i_shorter_filter_time (short_sel),
    .o_cnt                 (cnt_c1)
  );

  dsi3_chip_filter_counter #(.COUNT_VALUE(C2)) u_cnt_c2 (
    .clk_rst               (clk_rst),
    .i_arst_n              (i_arst_n),
    .i_input_value         (i_chip),
    .i_filtered_value      (filtered_chip),
    .i_shorter_filter_time (short_sel),
    .o_cnt                 (cnt_c2)
  );

  // ~~~~~~~~~~~~~~~~~~~~ Decision and registers
  dsi3_chip_filter_decision u_decision (
    .clk_rst               (clk_rst),
    .i_arst_n              (i_arst_n),
    .i_cnt_c0              (cnt_c0),
    .i_cnt_c1              (cnt_c1),
    .i_cnt_c2              (cnt_c2),
    .i_shorter_filter_time (short_sel),
    .o_filtered_chip       (filtered_chip),
    .o_chip_changed        (chg_pulse)
  );

  dsi3_filter_regs u_regs (
    .clk_rst               (clk_rst),
    .i_arst_n              (i_arst_n),
    .i_wb_cyc              (i_wb_cyc),
    .i_wb_stb              (i_wb_stb),
    .i_wb_we               (i_wb_we),
    .i_wb_adr              (i_wb_adr),
    .i_wb_dat              (i_wb_dat),
    .i_filtered_chip       (filtered_chip),
    .i_chip_changed        (chg_pulse),
    .o_wb_dat              (o_wb_dat),
    .o_wb_ack              (o_wb_ack),
    .o_shorter_filter_time (short_sel)
  );

endmodule : dsi3_chip_filter_top

`default_nettype wire

/* hdl/dsi3_filter_regs.sv */
// DSI3 chip filter register slave
// Wishbone classic slave with single-cycle ack holding the short filter time
// select, the filtered chip status and a saturating 16-bit transition counter

`timescale 1ns/1ns
`default_nettype none

module dsi3_filter_regs (
  input  wire                           clk_rst,
  input  wire                           i_arst_n,
  input  wire                           i_wb_cyc,
  input  wire                           i_wb_stb,
  input  wire                           i_wb_we,
  input  wire [dsi3_pkg::WB_AW-1:0]     i_wb_adr,        // Word address
  input  wire [31:0]                    i_wb_dat,
  input  wire dsi3_pkg::dsi3_chip       i_filtered_chip, // Current filter output
  input  wire                           i_chip_changed,  // One pulse per filter change
  output logic [31:0]                   o_wb_dat,
  output logic                          o_wb_ack,
  output logic                          o_shorter_filter_time
);

  import dsi3_pkg::*;

  logic        wb_req;                           // Transfer accepted this cycle
  logic        wr_ctrl;                          // Write to the control word
  logic        clr_cnt;                          // Software clear of the transition count
  logic [15:0] trans_cnt;                        // Number of filter output changes
  logic [31:0] rd_word;                          // Read mux output

  // ~~~~~~~~~~~~~~~~~~~~ Bus handshake
  // A request already answered by ack is not taken twice
  assign wb_req  = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign wr_ctrl = wb_req && i_wb_we && (i_wb_adr == ADDR_CTRL);
  assign clr_cnt = wr_ctrl && i_wb_dat[CTRL_CLEAR_BIT];

  always_ff @(posedge clk_rst or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= wb_req;                        // Ack follows the request by one cycle
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~ Control register
  always_ff @(posedge clk_rst or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_shorter_filter_time <= 1'b0;             // Long filter time after reset
    end else if (wr_ctrl) begin
      o_shorter_filter_time <= i_wb_dat[CTRL_SHORT_BIT];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~ Transition counter
  always_ff @(posedge clk_rst or negedge i_arst_n) begin
    if (!i_arst_n) begin
      trans_cnt <= '0;
    end else if (clr_cnt) begin
      trans_cnt <= '0;                           // Clear wins over a coincident change
    end else if (i_chip_changed && (trans_cnt != 16'hFFFF)) begin
      trans_cnt <= trans_cnt + 16'd1;            // Stops at full scale
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~ Read path
  always_comb begin
    rd_word = '0;                                // Unmapped words read as zero
    case (i_wb_adr)
      ADDR_CTRL: begin
        rd_word[CTRL_SHORT_BIT] = o_shorter_filter_time;  // Clear bit always reads 0
      end
      ADDR_STAT: begin
        rd_word[1:0]   = i_filtered_chip;
        rd_word[31:16] = trans_cnt;
      end
      default: begin
        rd_word = '0;
      end
    endcase
  end

  // Read data is captured with the request and is valid while ack is high
  always_ff @(posedge clk_rst) begin
    if (wb_req && !i_wb_we) begin
      o_wb_dat <= rd_word;
    end
  end

endmodule : dsi3_filter_regs

`default_nettype wire

/* hdl/dsi3_pkg.sv */
// DSI3 chip filter package
// Chip encoding, filter counter type, filter limits and
// the register map of the Wishbone register slave

`default_nettype none

package dsi3_pkg;

  // ~~~~~~~~~~~~~~~~~~~~ Chip values
  typedef enum logic [1:0] {
    C0 = 2'd0,                                  // Lowest comparator level
    C1 = 2'd1,                                  // Middle level
    C2 = 2'd2                                   // Highest level, code 3 is never valid
  } dsi3_chip;

  // ~~~~~~~~~~~~~~~~~~~~ Filter counters
  typedef logic [3:0] dsi3_filter_counter_t;    // Persistence count of one chip value

  localparam dsi3_filter_counter_t FILT_MAX_LONG  = 4'd15; // Limit in normal mode
  localparam dsi3_filter_counter_t FILT_MAX_SHORT = 4'd10; // Limit with short filter time

  // ~~~~~~~~~~~~~~~~~~~~ Register map
  localparam int unsigned WB_AW = 2;            // Word address width, data is 32 bit

  // Control word: bit 0 short filter time, bit 1 clears the transition count
  localparam logic [WB_AW-1:0] ADDR_CTRL = 2'd0;
  // Status word: bits 1:0 filtered chip, bits 31:16 transition count
  localparam logic [WB_AW-1:0] ADDR_STAT = 2'd1;

  localparam int unsigned CTRL_SHORT_BIT = 0;   // Short filter time select
  localparam int unsigned CTRL_CLEAR_BIT = 1;   // Write one to clear, reads as zero

endpackage : dsi3_pkg

`default_nettype wire
